//--- design/boot_rom.hex
// Boot image, one 32-bit hex word per line starting at word 0
00000093
00000113
00000193
00000213
00000293
00000313
00000393
00000413
00001137
ffc10113
00000517
0c050513
00000597
0bc58593
00b57863
00052023
00450513
feb56ce3
80000637
00100693
00d62023
00169693
0ff6f693
00069463
00100693
000f47b7
24078793
fff78793
fe079ee3
fddff06f
00000013
00000013
fe010113
00112e23
00812c23
02010413
fea42623
fec42783
00078513
01c12083
01812403
02010113
00008067
00050793
00058713
00e7a023
00008067
00052783
00f5a023
00008067
0005a703
00e52023
00008067
10000537
04100593
00b50023
00008067
30200073
00000073
00100073
0000100f
c0002573
c01025f3
40b50533
00008067
deadbeef
cafef00d
12345678
a5a5a5a5
5a5a5a5a
0f0f0f0f
f0f0f0f0
00ff00ff
ff00ff00
01234567
89abcdef
fedcba98
76543210
13579bdf
2468ace0

//--- all.f
+incdir+tests
design/soc_bus_pkg.sv
design/boot_rom.sv
design/data_ram.sv
design/led_port.sv
design/bus_decoder.sv
design/soc_bus_top.sv
tests/tb_soc_bus.sv

//--- Makefile
SIM := obj_dir/Vtb_soc_bus

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard design/*.sv tests/*.sv tests/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_soc_bus -f all.f -o Vtb_soc_bus

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Shadow copies of every readable location
logic [soc_bus_pkg::data_width-1:0] shadow_ram [ram_words];
logic [soc_bus_pkg::data_width-1:0] rom_image [rom_words];
logic [led_width-1:0]               shadow_led;

initial begin
    for (int i = 0; i < rom_words; i++) begin
        rom_image[i] = '0;  // Past the image
    end
    $readmemh("design/boot_rom.hex", rom_image);
end

function automatic void shadow_clear();
    for (int i = 0; i < ram_words; i++) begin
        shadow_ram[i] = '0;
    end
    shadow_led = '0;
endfunction

// Word offset wraps modulo the RAM size
function automatic int ram_index(logic [23:0] offset);
    return int'(offset[23:2]) % ram_words;
endfunction

function automatic logic expect_err(logic [31:0] addr);
    soc_bus_pkg::bus_addr_u a;
    a.raw = addr;
    return !(a.fields.region inside {soc_bus_pkg::region_ram, soc_bus_pkg::region_rom,
                                      soc_bus_pkg::region_led});
endfunction

function automatic logic [31:0] expect_rdata(logic [31:0] addr);
    soc_bus_pkg::bus_addr_u a;
    int                     rom_idx;
    a.raw   = addr;
    rom_idx = int'(a.fields.offset[9:2]);
    case (a.fields.region)
        soc_bus_pkg::region_rom: return (rom_idx < rom_words) ? rom_image[rom_idx] : '0;
        soc_bus_pkg::region_ram: return shadow_ram[ram_index(a.fields.offset)];
        soc_bus_pkg::region_led: return 32'(shadow_led);  // Zero extended
        default:                 return '0;
    endcase
endfunction

function automatic void shadow_write(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
    soc_bus_pkg::bus_addr_u a;
    int                     idx;
    a.raw = addr;
    idx   = ram_index(a.fields.offset);
    if (a.fields.region == soc_bus_pkg::region_ram) begin
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                shadow_ram[idx][8*i +: 8] = data[8*i +: 8];
            end
        end
    end else if (a.fields.region == soc_bus_pkg::region_led) begin
        shadow_led = data[led_width-1:0];
    end
endfunction

`endif

//--- tests/tb_soc_bus.sv
`timescale 1ns/1ns

module tb_soc_bus;

    localparam int rom_words   = 256;
    localparam int ram_words   = 1024;
    localparam int led_width   = 8;
    localparam int ack_timeout = 20;
    localparam int ram_window  = 32;

    logic                 system_if;
    logic                 rst_n;
    logic                 req;
    logic                 we;
    logic [31:0]          address;
    logic [31:0]          wdata;
    logic [3:0]           be;
    logic                 ack;
    logic                 err;
    logic [31:0]          rdata;
    logic [led_width-1:0] led;

    logic [15:0] lfsr_state    = 16'd30706;
    int          mismatch_errs = 0;
    int          timeout_errs  = 0;
    int          xfer_count    = 0;
    int          req_age       = 0;

    `include "tb_ref_model.svh"

    soc_bus_top #(
        .rom_words(rom_words),
        .ram_words(ram_words),
        .led_width(led_width)
    ) dut0 (
        .system_if(system_if), .rst_n(rst_n), .req(req), .we(we), .address(address),
        .wdata(wdata), .be(be), .ack(ack), .err(err), .rdata(rdata), .led(led)
    );

    initial begin
        system_if = 1'b0;
        forever #2 system_if = ~system_if;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(logic [7:0] region, logic [23:0] offset);
        soc_bus_pkg::bus_addr_u a;
        a.fields.region = region;
        a.fields.offset = offset;
        return a.raw;
    endfunction

    // Same RAM word, aliased through a random multiple of the RAM size
    function automatic logic [31:0] ram_addr(int word_sel);
        int word_off;
        word_off = word_sel + ram_words * int'(rand_bits(3));
        return make_addr(soc_bus_pkg::region_ram, 24'(word_off * 4));
    endfunction

    // One transfer, called and returning on a falling edge
    task automatic bus_xfer(logic w, logic [31:0] a, logic [31:0] d, logic [3:0] mask);
        int waited;
        we      = w;
        address = a;
        wdata   = d;
        be      = mask;
        req     = 1'b1;
        waited  = 0;
        do begin
            @(negedge system_if);
            waited++;
        end while (!ack && waited < ack_timeout);
        assert (ack) else begin
            timeout_errs++;
            $display("timeout: no ack for address %h after %0d cycles", a, waited);
        end
        @(negedge system_if);  // Rising edge in between samples ack high
        req = 1'b0;
        @(negedge system_if);
    endtask

    // Comparison, sampled on the rising edge before the DUT updates
    always @(posedge system_if) begin
        if (!rst_n) begin
            req_age = 0;
            shadow_clear();
        end else begin
            req_age = req ? req_age + 1 : 0;
            assert (ack == (req && req_age == 2)) else begin
                mismatch_errs++;
                $display("mismatch at %0t: ack %b with req high for %0d cycles",
                         $time, ack, req_age);
            end
            assert (ack || (rdata == '0 && !err)) else begin
                mismatch_errs++;
                $display("mismatch at %0t: rdata %h err %b while ack low", $time, rdata, err);
            end
            assert (led == shadow_led) else begin
                mismatch_errs++;
                $display("mismatch at %0t: led %h, expected %h", $time, led, shadow_led);
            end
            if (ack) begin
                xfer_count++;
                assert (err == expect_err(address)) else begin
                    mismatch_errs++;
                    $display("mismatch at %0t: err %b at address %h", $time, err, address);
                end
                // Error responses carry zero data on writes as well
                if (!we || expect_err(address)) begin
                    assert (rdata == expect_rdata(address)) else begin
                        mismatch_errs++;
                        $display("mismatch at %0t: read %h at address %h, expected %h",
                                 $time, rdata, address, expect_rdata(address));
                    end
                end
                if (we) begin
                    shadow_write(address, wdata, be);
                end
            end
        end
    end

    initial begin
        logic [7:0] region;
        logic [3:0] mask;
        int         word_sel;

        rst_n   = 1'b0;
        req     = 1'b0;
        we      = 1'b0;
        address = '0;
        wdata   = '0;
        be      = '0;
        repeat (16) @(negedge system_if);
        rst_n = 1'b1;
        repeat (8) @(negedge system_if);  // Idle bus

        // Whole ROM, then a write that must not stick
        for (int i = 0; i < rom_words; i++) begin
            bus_xfer(1'b0, make_addr(soc_bus_pkg::region_rom, 24'(i * 4)), '0, 4'hf);
        end
        bus_xfer(1'b1, make_addr(soc_bus_pkg::region_rom, 24'h000008), rand_bits(32), 4'hf);
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b0, make_addr(soc_bus_pkg::region_rom, 24'(i * 4)), '0, 4'hf);
        end

        for (int i = 0; i < ram_window; i++) begin
            bus_xfer(1'b1, ram_addr(i), rand_bits(32), 4'hf);
        end
        for (int i = 0; i < 200; i++) begin
            word_sel = int'(rand_bits(5)) % ram_window;
            mask     = 4'(rand_bits(4));
            if (mask == 4'h0) begin
                mask = 4'h1;
            end
            bus_xfer(1'(rand_bits(1)), ram_addr(word_sel), rand_bits(32), mask);
        end
        for (int i = 0; i < ram_window; i++) begin
            bus_xfer(1'b0, ram_addr(i), '0, 4'hf);
        end

        // LED register mirrored through the region
        for (int i = 0; i < 12; i++) begin
            bus_xfer(1'b1, make_addr(soc_bus_pkg::region_led, 24'(rand_bits(24))),
                     rand_bits(32), 4'(rand_bits(4)));
            bus_xfer(1'b0, make_addr(soc_bus_pkg::region_led, 24'(rand_bits(24))), '0, 4'hf);
        end

        for (int i = 0; i < 40; i++) begin
            region = 8'(rand_bits(8));
            if (region inside {soc_bus_pkg::region_ram, soc_bus_pkg::region_rom,
                               soc_bus_pkg::region_led}) begin
                region = region ^ 8'h40;  // Moves a mapped code off the map
            end
            bus_xfer(1'(rand_bits(1)), make_addr(region, 24'(rand_bits(24))),
                     rand_bits(32), 4'(rand_bits(4)));
        end

        repeat (4) @(negedge system_if);
        $display("checked %0d transfers: %0d mismatches, %0d timeouts",
                 xfer_count, mismatch_errs, timeout_errs);
        if (mismatch_errs == 0 && timeout_errs == 0 && xfer_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- design/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top #(
    parameter int rom_words = 256,
    parameter int ram_words = 1024,
    parameter int led_width = 8
) (
    input  logic                              system_if,
    input  logic                              rst_n,
    input  logic                              req,
    input  logic                              we,
    input  logic [soc_bus_pkg::addr_width-1:0] address,
    input  logic [soc_bus_pkg::data_width-1:0] wdata,
    input  logic [soc_bus_pkg::be_width-1:0]   be,
    output logic                              ack,
    output logic                              err,
    output logic [soc_bus_pkg::data_width-1:0] rdata,
    output logic [led_width-1:0]              led
);

    logic                                rom_req, ram_req, led_req;
    logic                                rom_ack, ram_ack, led_ack;
    logic [soc_bus_pkg::data_width-1:0]   rom_rdata, ram_rdata, led_rdata;
    logic [soc_bus_pkg::offset_width-1:0] offset;

    bus_decoder dec0 (
        .system_if(system_if), .rst_n(rst_n), .req(req), .address(address),
        .rom_req(rom_req), .ram_req(ram_req), .led_req(led_req), .offset(offset),
        .rom_ack(rom_ack), .ram_ack(ram_ack), .led_ack(led_ack),
        .rom_rdata(rom_rdata), .ram_rdata(ram_rdata), .led_rdata(led_rdata),
        .ack(ack), .err(err), .rdata(rdata)
    );

    boot_rom #(.rom_words(rom_words)) rom0 (
        .system_if(system_if), .rst_n(rst_n), .req(rom_req), .we(we),
        .offset(offset), .be(be), .wdata(wdata), .ack(rom_ack), .rdata(rom_rdata)
    );

    data_ram #(.ram_words(ram_words)) ram0 (
        .system_if(system_if), .rst_n(rst_n), .req(ram_req), .we(we),
        .offset(offset), .be(be), .wdata(wdata), .ack(ram_ack), .rdata(ram_rdata)
    );

    led_port #(.led_width(led_width)) led0 (
        .system_if(system_if), .rst_n(rst_n), .req(led_req), .we(we),
        .offset(offset), .be(be), .wdata(wdata), .ack(led_ack), .rdata(led_rdata),
        .led(led)
    );

endmodule

//--- design/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder (
    input  logic                                system_if,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic [soc_bus_pkg::addr_width-1:0]   address,
    output logic                                rom_req,
    output logic                                ram_req,
    output logic                                led_req,
    output logic [soc_bus_pkg::offset_width-1:0] offset,
    input  logic                                rom_ack,
    input  logic                                ram_ack,
    input  logic                                led_ack,
    input  logic [soc_bus_pkg::data_width-1:0]   rom_rdata,
    input  logic [soc_bus_pkg::data_width-1:0]   ram_rdata,
    input  logic [soc_bus_pkg::data_width-1:0]   led_rdata,
    output logic                                ack,
    output logic                                err,
    output logic [soc_bus_pkg::data_width-1:0]   rdata
);

    soc_bus_pkg::bus_addr_u addr_u;
    logic                   hit_rom;
    logic                   hit_ram;
    logic                   hit_led;
    logic                   bad_req;
    logic                   bad_pending;
    logic                   bad_ack;

    assign addr_u.raw = address;
    assign offset     = addr_u.fields.offset;

    assign hit_rom = addr_u.fields.region == soc_bus_pkg::region_rom;
    assign hit_ram = addr_u.fields.region == soc_bus_pkg::region_ram;
    assign hit_led = addr_u.fields.region == soc_bus_pkg::region_led;

    assign rom_req = req & hit_rom;
    assign ram_req = req & hit_ram;
    assign led_req = req & hit_led;
    assign bad_req = req & ~(hit_rom | hit_ram | hit_led);

    // Error responder, same one-cycle timing as a slave
    always_ff @(posedge system_if) begin
        if (!rst_n) begin
            bad_pending <= 1'b0;
        end else begin
            bad_pending <= bad_req;
        end
    end

    assign bad_ack = bad_pending & bad_req;

    // Unselected slaves drive zeros, so OR is enough
    assign ack   = rom_ack | ram_ack | led_ack | bad_ack;
    assign err   = bad_ack;
    assign rdata = rom_rdata | ram_rdata | led_rdata;

    // Only the selected target may answer
    a_one_responder : assert property (
        @(posedge system_if) disable iff (!rst_n)
        $onehot0({rom_ack, ram_ack, led_ack, bad_ack})
    );

endmodule

//--- design/led_port.sv
`timescale 1ns/1ns

module led_port #(
    parameter int led_width = 8
) (
    input  logic                                system_if,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                we,
    input  logic [soc_bus_pkg::offset_width-1:0] offset,
    input  logic [soc_bus_pkg::be_width-1:0]     be,
    input  logic [soc_bus_pkg::data_width-1:0]   wdata,
    output logic                                ack,
    output logic [soc_bus_pkg::data_width-1:0]   rdata,
    output logic [led_width-1:0]                led
);

    logic [led_width-1:0]               led_reg;
    logic [soc_bus_pkg::data_width-1:0] q;
    logic                               pending;

    // Single register mirrored across the whole region, so offset and be go unused
    assign ack   = pending & req;
    assign rdata = ack ? q : '0;
    assign led   = led_reg;

    always_ff @(posedge system_if) begin
        if (!rst_n) begin
            pending <= 1'b0;
            led_reg <= '0;
        end else begin
            pending <= req;
            if (ack && we) led_reg <= wdata[led_width-1:0];
        end
    end

    always_ff @(posedge system_if) begin
        q <= soc_bus_pkg::data_width'(led_reg);  // Zero extended
    end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int ram_words = 1024
) (
    input  logic                                system_if,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                we,
    input  logic [soc_bus_pkg::offset_width-1:0] offset,
    input  logic [soc_bus_pkg::be_width-1:0]     be,
    input  logic [soc_bus_pkg::data_width-1:0]   wdata,
    output logic                                ack,
    output logic [soc_bus_pkg::data_width-1:0]   rdata
);

    localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic [soc_bus_pkg::data_width-1:0] mem [ram_words];
    logic [soc_bus_pkg::data_width-1:0] q;
    logic [idx_w-1:0]                   idx;
    logic                               pending;

    // Word offset wraps over the array
    assign idx   = idx_w'(int'(offset[soc_bus_pkg::offset_width-1:2]) % ram_words);
    assign ack   = pending & req;
    assign rdata = ack ? q : '0;

    always_ff @(posedge system_if) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= req;
        end
    end

    always_ff @(posedge system_if) begin
        q <= mem[idx];
        if (ack && we) begin
            for (int i = 0; i < soc_bus_pkg::be_width; i++) begin
                if (be[i]) mem[idx][8*i +: 8] <= wdata[8*i +: 8];  // Byte lane i
            end
        end
    end

    a_write_has_be : assert property (
        @(posedge system_if) disable iff (!rst_n)
        (ack && we) |-> (be != '0)
    );

endmodule

//--- design/boot_rom.sv
`timescale 1ns/1ns

module boot_rom #(
    parameter int rom_words = 256
) (
    input  logic                                system_if,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                we,
    input  logic [soc_bus_pkg::offset_width-1:0] offset,
    input  logic [soc_bus_pkg::be_width-1:0]     be,
    input  logic [soc_bus_pkg::data_width-1:0]   wdata,
    output logic                                ack,
    output logic [soc_bus_pkg::data_width-1:0]   rdata
);

    logic [soc_bus_pkg::data_width-1:0] mem [rom_words];
    logic [soc_bus_pkg::data_width-1:0] q;
    logic [7:0]                         word_idx;
    logic                               pending;

    // Zero fill first so words past the image read as zero
    initial begin
        for (int i = 0; i < rom_words; i++) begin
            mem[i] = '0;
        end
        $readmemh("design/boot_rom.hex", mem);
    end

    assign word_idx = offset[9:2];
    assign ack      = pending & req;
    assign rdata    = ack ? q : '0;

    always_ff @(posedge system_if) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= req;
        end
    end

    // Read word, registered alongside the pending flag
    always_ff @(posedge system_if) begin
        q <= (int'(word_idx) < rom_words) ? mem[word_idx] : '0;
    end

    // Write side (we, be, wdata) is ignored; the ROM only acknowledges

    // Master keeps req and the word address until the ack arrives
    a_req_held : assert property (
        @(posedge system_if) disable iff (!rst_n)
        (req && !ack) |=> req && $stable(offset)
    );

endmodule

//--- design/soc_bus_pkg.sv
package soc_bus_pkg;

    // Bus widths
    localparam int data_width   = 32;
    localparam int addr_width   = 32;
    localparam int region_width = 8;
    localparam int offset_width = addr_width - region_width;
    localparam int be_width     = data_width / 8;

    // Region codes, taken from the high address byte
    localparam logic [region_width-1:0] region_ram = 8'h00;
    localparam logic [region_width-1:0] region_rom = 8'h01;
    localparam logic [region_width-1:0] region_led = 8'h80;

    // Bus address, either as a flat byte address or split by region
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [region_width-1:0] region;
            logic [offset_width-1:0] offset;
        } fields;
    } bus_addr_u;

endpackage
